// ==== design/core_pkg.sv ====
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [3:0]  strb_t;

  // RV32I major opcodes handled by the core
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011
  } opcode_e;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    strb_t wstrb;
    logic  we;
  } mem_req_t;

  typedef struct packed {
    word_t rdata;
  } mem_rsp_t;

  // One retired instruction
  typedef struct packed {
    word_t    pc;
    reg_idx_t rd;
    word_t    wdata;
    logic     we;
  } commit_t;

endpackage

// ==== design/reg_file.sv ====
module reg_file import core_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     we_i,
  input  reg_idx_t waddr_i,
  input  word_t    wdata_i,
  input  reg_idx_t raddr1_i,
  input  reg_idx_t raddr2_i,
  output word_t    rdata1_o,
  output word_t    rdata2_o
);

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      // x0 never written so it stays zero
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = regs[raddr1_i];
  assign rdata2_o = regs[raddr2_i];

endmodule

// ==== design/fetch_unit.sv ====
module fetch_unit import core_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic     clk,
  input  logic     rst,
  output logic     req_valid_o,
  output mem_req_t req_o,
  input  logic     grant_i,
  input  logic     rsp_valid_i,
  input  mem_rsp_t rsp_i,
  output logic     inst_valid_o,
  output word_t    inst_o,
  output word_t    inst_pc_o,
  input  logic     inst_ready_i,
  input  logic     redirect_i,
  input  word_t    redirect_pc_i
);

  word_t pc_q, req_pc_q, buf_inst_q, buf_pc_q;
  logic  pending_q, drop_q, buf_valid_q;
  logic  issue, take;

  // One fetch in flight at most, and only into an empty buffer
  assign req_valid_o = !pending_q && !buf_valid_q;
  assign req_o       = '{addr: pc_q, wdata: '0, wstrb: '0, we: 1'b0};
  assign issue       = req_valid_o && grant_i;
  assign take        = buf_valid_q && inst_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q        <= RESET_PC;
      pending_q   <= 1'b0;
      drop_q      <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      if (issue) begin
        pending_q <= 1'b1;
        pc_q      <= pc_q + word_t'(4);
      end
      if (rsp_valid_i) begin
        pending_q <= 1'b0;
        if (drop_q) begin
          drop_q <= 1'b0;
        end else if (!redirect_i) begin
          buf_valid_q <= 1'b1;
        end
      end
      if (take) begin
        buf_valid_q <= 1'b0;
      end
      if (redirect_i) begin
        pc_q        <= redirect_pc_i;
        buf_valid_q <= 1'b0;
        // Fetch still outstanding belongs to the old path
        if (issue || (pending_q && !rsp_valid_i)) begin
          drop_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      req_pc_q <= pc_q;
    end
    if (rsp_valid_i) begin
      buf_inst_q <= rsp_i.rdata;
      buf_pc_q   <= req_pc_q;
    end
  end

  assign inst_valid_o = buf_valid_q;
  assign inst_o       = buf_inst_q;
  assign inst_pc_o    = buf_pc_q;

endmodule

// ==== design/decode_exec.sv ====
module decode_exec import core_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     inst_valid_i,
  input  word_t    inst_i,
  input  word_t    inst_pc_i,
  output logic     inst_ready_o,
  output logic     redirect_o,
  output word_t    redirect_pc_o,
  output reg_idx_t rf_raddr1_o,
  output reg_idx_t rf_raddr2_o,
  input  word_t    rf_rdata1_i,
  input  word_t    rf_rdata2_i,
  output logic     rf_we_o,
  output reg_idx_t rf_waddr_o,
  output word_t    rf_wdata_o,
  output logic     ls_valid_o,
  output logic     ls_we_o,
  output word_t    ls_addr_o,
  output word_t    ls_wdata_o,
  input  logic     ls_done_i,
  input  word_t    ls_rdata_i,
  output logic     commit_valid_o,
  output commit_t  commit_o
);

  typedef enum logic [1:0] {S_IDLE, S_EXEC, S_MEM_WAIT} state_e;

  state_e   state_q;
  word_t    inst_q, pc_q, load_q;
  logic     mem_done_q;
  opcode_e  op;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t rd;
  word_t    imm_i, imm_s, imm_b, imm_u, alu_res, wb_data;
  logic     alu_we, is_load, is_store, is_beq, is_mem, wb_we, do_commit;

  assign op     = opcode_e'(inst_q[6:0]);
  assign funct3 = inst_q[14:12];
  assign funct7 = inst_q[31:25];
  assign rd     = inst_q[11:7];
  assign imm_i  = {{20{inst_q[31]}}, inst_q[31:20]};
  assign imm_s  = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
  assign imm_b  = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
  assign imm_u  = {inst_q[31:12], 12'b0};

  assign rf_raddr1_o = inst_q[19:15];
  assign rf_raddr2_o = inst_q[24:20];

  // Anything not matched below falls through as a NOP
  always_comb begin
    alu_we   = 1'b0;
    is_load  = 1'b0;
    is_store = 1'b0;
    is_beq   = 1'b0;
    alu_res  = '0;
    case (op)
      OP_IMM: begin
        if (funct3 == 3'b000) begin
          alu_we  = 1'b1;
          alu_res = rf_rdata1_i + imm_i;
        end
      end
      OP: begin
        if (funct7 == 7'b0000000) begin
          alu_we = 1'b1;
          case (funct3)
            3'b000:  alu_res = rf_rdata1_i + rf_rdata2_i;
            3'b100:  alu_res = rf_rdata1_i ^ rf_rdata2_i;
            3'b110:  alu_res = rf_rdata1_i | rf_rdata2_i;
            3'b111:  alu_res = rf_rdata1_i & rf_rdata2_i;
            default: alu_we = 1'b0;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          alu_we  = 1'b1;
          alu_res = rf_rdata1_i - rf_rdata2_i;
        end
      end
      LUI: begin
        alu_we  = 1'b1;
        alu_res = imm_u;
      end
      LOAD:    is_load  = (funct3 == 3'b010);
      STORE:   is_store = (funct3 == 3'b010);
      BRANCH:  is_beq   = (funct3 == 3'b000);
      default: ;
    endcase
  end

  assign is_mem    = is_load || is_store;
  assign do_commit = (state_q == S_EXEC) && (!is_mem || mem_done_q);
  assign wb_we     = alu_we || is_load;
  assign wb_data   = is_load ? load_q : alu_res;

  assign inst_ready_o  = (state_q == S_IDLE);
  assign redirect_o    = (state_q == S_EXEC) && is_beq && (rf_rdata1_i == rf_rdata2_i);
  assign redirect_pc_o = pc_q + imm_b;

  assign ls_valid_o = (state_q == S_EXEC) && is_mem && !mem_done_q;
  assign ls_we_o    = is_store;
  assign ls_addr_o  = rf_rdata1_i + (is_store ? imm_s : imm_i);
  assign ls_wdata_o = rf_rdata2_i;

  assign rf_we_o    = do_commit && wb_we;
  assign rf_waddr_o = rd;
  assign rf_wdata_o = wb_data;

  assign commit_valid_o = do_commit;
  assign commit_o       = '{pc: pc_q, rd: wb_we ? rd : '0, wdata: wb_we ? wb_data : '0, we: wb_we};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= S_IDLE;
      mem_done_q <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (inst_valid_i) begin
            state_q <= S_EXEC;
          end
        end
        S_EXEC: begin
          if (ls_valid_o) begin
            state_q <= S_MEM_WAIT;
          end else begin
            state_q    <= S_IDLE;
            mem_done_q <= 1'b0;
          end
        end
        S_MEM_WAIT: begin
          // Back to execute for the write-back and commit
          if (ls_done_i) begin
            state_q    <= S_EXEC;
            mem_done_q <= 1'b1;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (inst_ready_o && inst_valid_i) begin
      inst_q <= inst_i;
      pc_q   <= inst_pc_i;
    end
    if (state_q == S_MEM_WAIT && ls_done_i) begin
      load_q <= ls_rdata_i;
    end
  end

endmodule

// ==== design/load_store_unit.sv ====
module load_store_unit import core_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     ls_valid_i,
  input  logic     ls_we_i,
  input  word_t    ls_addr_i,
  input  word_t    ls_wdata_i,
  output logic     ls_done_o,
  output word_t    ls_rdata_o,
  output logic     req_valid_o,
  output mem_req_t req_o,
  input  logic     grant_i,
  input  logic     rsp_valid_i,
  input  mem_rsp_t rsp_i
);

  typedef enum logic [1:0] {LS_IDLE, LS_REQ, LS_WAIT} ls_state_e;

  ls_state_e state_q;
  word_t     addr_q, wdata_q;
  logic      we_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= LS_IDLE;
    end else begin
      case (state_q)
        LS_IDLE: if (ls_valid_i) state_q <= LS_REQ;
        LS_REQ:  if (grant_i) state_q <= LS_WAIT;
        // Store response doubles as the write acknowledge
        LS_WAIT: if (rsp_valid_i) state_q <= LS_IDLE;
        default: state_q <= LS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == LS_IDLE && ls_valid_i) begin
      addr_q  <= {ls_addr_i[31:2], 2'b00};
      wdata_q <= ls_wdata_i;
      we_q    <= ls_we_i;
    end
  end

  assign req_valid_o = (state_q == LS_REQ);
  assign req_o       = '{addr: addr_q, wdata: wdata_q, wstrb: {4{we_q}}, we: we_q};
  assign ls_done_o   = (state_q == LS_WAIT) && rsp_valid_i;
  assign ls_rdata_o  = rsp_i.rdata;

endmodule

// ==== design/mem_arbiter.sv ====
module mem_arbiter import core_pkg::*; #(
  parameter int MEM_CREDITS = 2
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     lsu_req_valid_i,
  input  mem_req_t lsu_req_i,
  output logic     lsu_grant_o,
  input  logic     ifu_req_valid_i,
  input  mem_req_t ifu_req_i,
  output logic     ifu_grant_o,
  output logic     lsu_rsp_valid_o,
  output logic     ifu_rsp_valid_o,
  output mem_rsp_t rsp_o,
  output logic     mem_req_valid_o,
  output mem_req_t mem_req_o,
  input  logic     mem_rsp_valid_i,
  input  mem_rsp_t mem_rsp_i,
  input  logic     mem_credit_i
);

  localparam int CW = $clog2(MEM_CREDITS + 1);

  logic [CW-1:0] credit_q;
  logic          has_credit, issue, head_is_lsu;
  // Owner of each outstanding request where 1 means LSU
  logic          owner_q [2];
  logic          wr_ptr_q, rd_ptr_q;

  assign has_credit = (credit_q != '0);

  // LSU wins over fetch
  assign lsu_grant_o     = lsu_req_valid_i && has_credit;
  assign ifu_grant_o     = ifu_req_valid_i && !lsu_req_valid_i && has_credit;
  assign mem_req_valid_o = has_credit && (lsu_req_valid_i || ifu_req_valid_i);
  assign mem_req_o       = lsu_req_valid_i ? lsu_req_i : ifu_req_i;
  assign issue           = mem_req_valid_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      credit_q <= CW'(MEM_CREDITS);
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      case ({issue, mem_credit_i})
        2'b10:   credit_q <= credit_q - CW'(1);
        2'b01:   credit_q <= credit_q + CW'(1);
        default: ;
      endcase
      if (issue) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (mem_rsp_valid_i) begin
        rd_ptr_q <= !rd_ptr_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      owner_q[wr_ptr_q] <= lsu_req_valid_i;
    end
  end

  // Responses come back in order so the FIFO head names the owner
  assign head_is_lsu     = owner_q[rd_ptr_q];
  assign lsu_rsp_valid_o = mem_rsp_valid_i && head_is_lsu;
  assign ifu_rsp_valid_o = mem_rsp_valid_i && !head_is_lsu;
  assign rsp_o           = mem_rsp_i;

endmodule

// ==== design/core_top.sv ====
module core_top import core_pkg::*; #(
  parameter int    MEM_CREDITS = 2,
  parameter word_t RESET_PC    = '0
) (
  input  logic     clk,
  input  logic     rst,
  output logic     mem_req_valid_o,
  output mem_req_t mem_req_o,
  input  logic     mem_rsp_valid_i,
  input  mem_rsp_t mem_rsp_i,
  input  logic     mem_credit_i,
  output logic     commit_valid_o,
  output commit_t  commit_o
);

  logic     ifu_req_valid, ifu_grant, ifu_rsp_valid;
  logic     lsu_req_valid, lsu_grant, lsu_rsp_valid;
  mem_req_t ifu_req, lsu_req;
  mem_rsp_t rsp;
  logic     inst_valid, inst_ready, redirect;
  word_t    inst, inst_pc, redirect_pc;
  reg_idx_t rf_raddr1, rf_raddr2, rf_waddr;
  word_t    rf_rdata1, rf_rdata2, rf_wdata;
  logic     rf_we;
  logic     ls_valid, ls_we, ls_done;
  word_t    ls_addr, ls_wdata, ls_rdata;

  reg_file u_rf (
    .clk(clk), .rst(rst),
    .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
    .raddr1_i(rf_raddr1), .raddr2_i(rf_raddr2),
    .rdata1_o(rf_rdata1), .rdata2_o(rf_rdata2)
  );

  fetch_unit #(.RESET_PC(RESET_PC)) u_ifu (
    .clk(clk), .rst(rst),
    .req_valid_o(ifu_req_valid), .req_o(ifu_req), .grant_i(ifu_grant),
    .rsp_valid_i(ifu_rsp_valid), .rsp_i(rsp),
    .inst_valid_o(inst_valid), .inst_o(inst), .inst_pc_o(inst_pc),
    .inst_ready_i(inst_ready),
    .redirect_i(redirect), .redirect_pc_i(redirect_pc)
  );

  decode_exec u_dx (
    .clk(clk), .rst(rst),
    .inst_valid_i(inst_valid), .inst_i(inst), .inst_pc_i(inst_pc),
    .inst_ready_o(inst_ready),
    .redirect_o(redirect), .redirect_pc_o(redirect_pc),
    .rf_raddr1_o(rf_raddr1), .rf_raddr2_o(rf_raddr2),
    .rf_rdata1_i(rf_rdata1), .rf_rdata2_i(rf_rdata2),
    .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
    .ls_valid_o(ls_valid), .ls_we_o(ls_we), .ls_addr_o(ls_addr), .ls_wdata_o(ls_wdata),
    .ls_done_i(ls_done), .ls_rdata_i(ls_rdata),
    .commit_valid_o(commit_valid_o), .commit_o(commit_o)
  );

  load_store_unit u_lsu (
    .clk(clk), .rst(rst),
    .ls_valid_i(ls_valid), .ls_we_i(ls_we), .ls_addr_i(ls_addr), .ls_wdata_i(ls_wdata),
    .ls_done_o(ls_done), .ls_rdata_o(ls_rdata),
    .req_valid_o(lsu_req_valid), .req_o(lsu_req), .grant_i(lsu_grant),
    .rsp_valid_i(lsu_rsp_valid), .rsp_i(rsp)
  );

  mem_arbiter #(.MEM_CREDITS(MEM_CREDITS)) u_arb (
    .clk(clk), .rst(rst),
    .lsu_req_valid_i(lsu_req_valid), .lsu_req_i(lsu_req), .lsu_grant_o(lsu_grant),
    .ifu_req_valid_i(ifu_req_valid), .ifu_req_i(ifu_req), .ifu_grant_o(ifu_grant),
    .lsu_rsp_valid_o(lsu_rsp_valid), .ifu_rsp_valid_o(ifu_rsp_valid), .rsp_o(rsp),
    .mem_req_valid_o(mem_req_valid_o), .mem_req_o(mem_req_o),
    .mem_rsp_valid_i(mem_rsp_valid_i), .mem_rsp_i(mem_rsp_i), .mem_credit_i(mem_credit_i)
  );

endmodule

// ==== sim/core_sva.sv ====
module core_sva #(
  parameter int MEM_CREDITS = 2
) (
  input logic clk,
  input logic rst,
  input logic req_valid_i,
  input logic credit_i,
  input logic commit_valid_i
);

  int outstanding_q;
  int fail_cnt = 0;

  // Requests issued minus credits returned
  always_ff @(posedge clk) begin
    if (rst) begin
      outstanding_q <= 0;
    end else begin
      outstanding_q <= outstanding_q + int'(req_valid_i) - int'(credit_i);
    end
  end

  a_credit_limit: assert property (@(posedge clk) disable iff (rst)
    outstanding_q <= MEM_CREDITS)
    else begin
      $error("More requests outstanding than the credit limit allows");
      fail_cnt++;
    end

  a_no_req_without_credit: assert property (@(posedge clk) disable iff (rst)
    outstanding_q == MEM_CREDITS |-> !req_valid_i)
    else begin
      $error("Memory request issued with no credit left");
      fail_cnt++;
    end

  a_no_commit_in_reset: assert property (@(posedge clk)
    rst |=> !commit_valid_i)
    else begin
      $error("Commit valid while the core is held in reset");
      fail_cnt++;
    end

endmodule

bind core_top core_sva #(.MEM_CREDITS(MEM_CREDITS)) u_sva (
  .clk(clk),
  .rst(rst),
  .req_valid_i(mem_req_valid_o),
  .credit_i(mem_credit_i),
  .commit_valid_i(commit_valid_o)
);

// ==== sim/core_tb.sv ====
module core_tb import core_pkg::*; ();

  localparam int    MEM_CREDITS = 2;
  localparam int    PROG_LEN    = 60;
  localparam int    MEM_WORDS   = 1024;
  localparam int    MAX_CYCLES  = 20000;
  localparam word_t LOOP_PC     = 32'((PROG_LEN - 1) * 4);

  logic     clk;
  logic     rst;
  logic     mem_req_valid_o;
  mem_req_t mem_req_o;
  logic     mem_rsp_valid_i;
  mem_rsp_t mem_rsp_i;
  logic     mem_credit_i;
  logic     commit_valid_o;
  commit_t  commit_o;

  word_t    lfsr_q;
  word_t    mem [MEM_WORDS];
  word_t    model_mem [MEM_WORDS];
  // Kind codes are 0 ADDI, 1 ADD, 2 SUB, 3 AND, 4 OR, 5 XOR, 6 LUI, 7 LW, 8 SW, 9 BEQ
  int       kind_a [PROG_LEN];
  reg_idx_t rd_a [PROG_LEN];
  reg_idx_t rs1_a [PROG_LEN];
  reg_idx_t rs2_a [PROG_LEN];
  word_t    imm_a [PROG_LEN];
  commit_t  exp_commits [$];
  mem_req_t exp_stores [$];
  word_t    rsp_data_q [$];
  int       rsp_delay_q [$];
  int       loop_hits;

  core_top #(.MEM_CREDITS(MEM_CREDITS), .RESET_PC('0)) dut0 (
    .clk(clk),
    .rst(rst),
    .mem_req_valid_o(mem_req_valid_o),
    .mem_req_o(mem_req_o),
    .mem_rsp_valid_i(mem_rsp_valid_i),
    .mem_rsp_i(mem_rsp_i),
    .mem_credit_i(mem_credit_i),
    .commit_valid_o(commit_valid_o),
    .commit_o(commit_o)
  );

  always #10 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic word_t rand_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic word_t fill_word(input word_t addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h9E37_79B9;
  endfunction

  task automatic check_commit(input commit_t got, input commit_t exp);
    if (got !== exp) begin
      abort_run($sformatf(
        "Mismatch commit_o: got pc=%h rd=%h wdata=%h we=%h expected pc=%h rd=%h wdata=%h we=%h",
        got.pc, got.rd, got.wdata, got.we, exp.pc, exp.rd, exp.wdata, exp.we));
    end
  endtask

  task automatic check_req(input mem_req_t got, input mem_req_t exp);
    if (got !== exp) begin
      abort_run($sformatf(
        "Mismatch mem_req_o: got addr=%h wdata=%h wstrb=%h we=%h expected addr=%h wdata=%h wstrb=%h we=%h",
        got.addr, got.wdata, got.wstrb, got.we, exp.addr, exp.wdata, exp.wstrb, exp.we));
    end
  endtask

  task automatic build_program();
    word_t inst;
    word_t imm;
    int    k;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]       = fill_word(word_t'(i * 4));
      model_mem[i] = mem[i];
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      kind_a[i] = int'(rand_bits(4)) % 10;
      rd_a[i]   = reg_idx_t'(rand_bits(3));
      rs1_a[i]  = reg_idx_t'(rand_bits(3));
      rs2_a[i]  = reg_idx_t'(rand_bits(3));
      case (kind_a[i])
        6: imm = rand_bits(20) << 12;
        7, 8: begin
          // Unaligned low address bits for the LSU to drop
          imm      = 32'h400 + (rand_bits(6) << 2) + rand_bits(2);
          rs1_a[i] = '0;
        end
        9: begin
          k = 1 + int'(rand_bits(2));
          if (i + k > PROG_LEN - 1) begin
            k = PROG_LEN - 1 - i;
          end
          imm = word_t'(k * 4);
        end
        default: begin
          imm = rand_bits(12);
          imm = {{20{imm[11]}}, imm[11:0]};
        end
      endcase
      // Last slot is the BEQ x0,x0,0 self-loop
      if (i == PROG_LEN - 1) begin
        kind_a[i] = 9;
        rs1_a[i]  = '0;
        rs2_a[i]  = '0;
        imm       = '0;
      end
      imm_a[i] = imm;
      case (kind_a[i])
        0: inst = {imm[11:0], rs1_a[i], 3'b000, rd_a[i], 7'h13};
        1: inst = {7'h00, rs2_a[i], rs1_a[i], 3'b000, rd_a[i], 7'h33};
        2: inst = {7'h20, rs2_a[i], rs1_a[i], 3'b000, rd_a[i], 7'h33};
        3: inst = {7'h00, rs2_a[i], rs1_a[i], 3'b111, rd_a[i], 7'h33};
        4: inst = {7'h00, rs2_a[i], rs1_a[i], 3'b110, rd_a[i], 7'h33};
        5: inst = {7'h00, rs2_a[i], rs1_a[i], 3'b100, rd_a[i], 7'h33};
        6: inst = {imm[31:12], rd_a[i], 7'h37};
        7: inst = {imm[11:0], 5'd0, 3'b010, rd_a[i], 7'h03};
        8: inst = {imm[11:5], rs2_a[i], 5'd0, 3'b010, imm[4:0], 7'h23};
        default: inst = {imm[12], imm[10:5], rs2_a[i], rs1_a[i], 3'b000, imm[4:1], imm[11], 7'h63};
      endcase
      mem[i] = inst;
    end
  endtask

  // Reference model that runs until the self-loop has retired three times
  task automatic run_model();
    word_t regs [32];
    word_t pc, a, b, res, addr;
    logic  we, taken;
    int    idx, loops;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    pc    = '0;
    loops = 0;
    while (loops < 3) begin
      idx   = int'(pc >> 2);
      a     = regs[rs1_a[idx]];
      b     = regs[rs2_a[idx]];
      addr  = a + imm_a[idx];
      we    = 1'b1;
      taken = 1'b0;
      res   = '0;
      case (kind_a[idx])
        0: res = a + imm_a[idx];
        1: res = a + b;
        2: res = a - b;
        3: res = a & b;
        4: res = a | b;
        5: res = a ^ b;
        6: res = imm_a[idx];
        7: res = model_mem[addr[11:2]];
        8: begin
          we = 1'b0;
          exp_stores.push_back('{addr: {addr[31:2], 2'b00}, wdata: b, wstrb: 4'hF, we: 1'b1});
          model_mem[addr[11:2]] = b;
        end
        default: begin
          we    = 1'b0;
          taken = (a == b);
        end
      endcase
      exp_commits.push_back('{pc: pc, rd: we ? rd_a[idx] : '0, wdata: we ? res : '0, we: we});
      if (we && rd_a[idx] != '0) begin
        regs[rd_a[idx]] = res;
      end
      if (pc == LOOP_PC) begin
        loops++;
      end
      pc = taken ? pc + imm_a[idx] : pc + 32'd4;
    end
  endtask

  task automatic accept_request(input mem_req_t req);
    if (req.addr >= word_t'(MEM_WORDS * 4)) begin
      abort_run("Memory request outside the modelled address range");
    end else if (req.we && exp_stores.size() == 0) begin
      abort_run("Write request seen with no store left in the reference model");
    end else begin
      if (req.we) begin
        check_req(req, exp_stores.pop_front());
        mem[req.addr[11:2]] = req.wdata;
        rsp_data_q.push_back('0);
      end else begin
        rsp_data_q.push_back(mem[req.addr[11:2]]);
      end
      rsp_delay_q.push_back(1 + int'(rand_bits(2)));
    end
  endtask

  // In-order memory model returning a credit with each response
  always @(posedge clk) begin
    if (rst) begin
      mem_rsp_valid_i <= 1'b0;
      mem_rsp_i       <= '0;
      mem_credit_i    <= 1'b0;
      rsp_data_q.delete();
      rsp_delay_q.delete();
    end else begin
      if (mem_req_valid_o) begin
        accept_request(mem_req_o);
      end
      mem_rsp_valid_i <= 1'b0;
      mem_credit_i    <= 1'b0;
      if (rsp_delay_q.size() > 0) begin
        if (rsp_delay_q[0] <= 1) begin
          mem_rsp_valid_i <= 1'b1;
          mem_credit_i    <= 1'b1;
          mem_rsp_i.rdata <= rsp_data_q.pop_front();
          void'(rsp_delay_q.pop_front());
        end else begin
          rsp_delay_q[0] = rsp_delay_q[0] - 1;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (!rst && commit_valid_o) begin
      if (exp_commits.size() == 0) begin
        abort_run("Commit seen after the reference model ran out of instructions");
      end else begin
        check_commit(commit_o, exp_commits.pop_front());
        if (commit_o.pc == LOOP_PC) begin
          loop_hits <= loop_hits + 1;
        end
      end
    end
  end

  initial begin
    int cycles;
    clk             = 1'b0;
    rst             = 1'b1;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_i       = '0;
    mem_credit_i    = 1'b0;
    lfsr_q          = 32'd62;
    loop_hits       = 0;
    build_program();
    run_model();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    cycles = 0;
    while (loop_hits < 3 && cycles < MAX_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (loop_hits < 3) begin
      abort_run("Timeout waiting for the self-loop to commit three times");
    end else if (dut0.u_sva.fail_cnt != 0) begin
      abort_run("A bound assertion on the memory port or the commit port failed");
    end else if (exp_commits.size() != 0 || exp_stores.size() != 0) begin
      abort_run("Run ended with model instructions or stores still unchecked");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

// ==== sim.f ====
design/core_pkg.sv
design/reg_file.sv
design/fetch_unit.sv
design/decode_exec.sv
design/load_store_unit.sv
design/mem_arbiter.sv
design/core_top.sv
sim/core_sva.sv
sim/core_tb.sv
